/* hw/la_pkg.sv */
package la_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [11:0] alu_op_t; // one-hot, see bit positions below

    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } cpu_state_t;

    // bit positions inside alu_op_t
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // register and shift forms match instr[31:15]
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // si12 forms match instr[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    localparam logic [6:0] op_lu12i_w = 7'h0a; // instr[31:25]

    // branch forms match instr[31:26]
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;

endpackage

/* hw/la_decoder.sv */
`timescale 1ns/1ps

module la_decoder import la_pkg::*; (
    input  word_t    instr,
    output reg_idx_t rd,
    output reg_idx_t rj,
    output reg_idx_t rk,
    output alu_op_t  alu_op,
    output word_t    imm,
    output logic     src1_is_pc,
    output logic     src2_is_imm,
    output logic     src_reg_is_rd,
    output logic     is_load,
    output logic     is_store,
    output logic     is_branch_cond_eq,
    output logic     is_branch_cond_ne,
    output logic     is_jump_pc_rel,
    output logic     is_jirl,
    output logic     writes_reg,
    output logic     dest_is_r1
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;

    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_lu12i_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;

    logic need_ui5;
    logic need_si12;
    logic need_si20;
    logic need_si16;

    assign op17 = instr[31:15];
    assign op10 = instr[31:22];
    assign op7  = instr[31:25];
    assign op6  = instr[31:26];

    assign rd = instr[4:0];
    assign rj = instr[9:5];
    assign rk = instr[14:10];

    assign inst_add_w   = op17 == op_add_w;
    assign inst_sub_w   = op17 == op_sub_w;
    assign inst_slt     = op17 == op_slt;
    assign inst_sltu    = op17 == op_sltu;
    assign inst_nor     = op17 == op_nor;
    assign inst_and     = op17 == op_and;
    assign inst_or      = op17 == op_or;
    assign inst_xor     = op17 == op_xor;
    assign inst_slli_w  = op17 == op_slli_w;
    assign inst_srli_w  = op17 == op_srli_w;
    assign inst_srai_w  = op17 == op_srai_w;
    assign inst_addi_w  = op10 == op_addi_w;
    assign inst_ld_w    = op10 == op_ld_w;
    assign inst_st_w    = op10 == op_st_w;
    assign inst_lu12i_w = op7 == op_lu12i_w;
    assign inst_jirl    = op6 == op_jirl;
    assign inst_b       = op6 == op_b;
    assign inst_bl      = op6 == op_bl;
    assign inst_beq     = op6 == op_beq;
    assign inst_bne     = op6 == op_bne;

    always_comb begin
        alu_op = '0;
        alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_jirl | inst_bl; // links compute pc + 4
        alu_op[alu_sub]  = inst_sub_w;
        alu_op[alu_slt]  = inst_slt;
        alu_op[alu_sltu] = inst_sltu;
        alu_op[alu_and]  = inst_and;
        alu_op[alu_nor]  = inst_nor;
        alu_op[alu_or]   = inst_or;
        alu_op[alu_xor]  = inst_xor;
        alu_op[alu_sll]  = inst_slli_w;
        alu_op[alu_srl]  = inst_srli_w;
        alu_op[alu_sra]  = inst_srai_w;
        alu_op[alu_lui]  = inst_lu12i_w;
    end

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_ld_w | inst_st_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si16 = inst_jirl | inst_beq | inst_bne;

    always_comb begin
        if (need_ui5) begin
            imm = {27'b0, instr[14:10]};
        end else if (need_si12) begin
            imm = {{20{instr[21]}}, instr[21:10]};
        end else if (need_si20) begin
            imm = {instr[24:5], 12'b0};
        end else if (need_si16) begin
            imm = {{14{instr[25]}}, instr[25:10], 2'b00};
        end else begin
            imm = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00}; // b and bl offset
        end
    end

    assign src1_is_pc    = inst_jirl | inst_bl;
    assign src2_is_imm   = need_ui5 | need_si12 | need_si20;
    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    assign is_load           = inst_ld_w;
    assign is_store          = inst_st_w;
    assign is_branch_cond_eq = inst_beq;
    assign is_branch_cond_ne = inst_bne;
    assign is_jump_pc_rel    = inst_b | inst_bl;
    assign is_jirl           = inst_jirl;
    assign dest_is_r1        = inst_bl;

    assign writes_reg = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                      | inst_and | inst_or | inst_xor | need_ui5 | inst_addi_w
                      | inst_lu12i_w | inst_ld_w | inst_jirl | inst_bl;

endmodule

/* hw/la_alu.sv */
`timescale 1ns/1ps

module la_alu import la_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result
);

    word_t       adder_b;
    logic        adder_cin;
    logic [32:0] adder_sum;
    word_t       add_sub_res;
    word_t       slt_res;
    word_t       sltu_res;
    word_t       sll_res;
    word_t       srl_res;
    word_t       sra_res;
    logic [4:0]  shamt;

    // sub and both compares share the adder as src1 + ~src2 + 1
    assign adder_cin   = alu_op[alu_sub] | alu_op[alu_slt] | alu_op[alu_sltu];
    assign adder_b     = adder_cin ? ~src2 : src2;
    assign adder_sum   = {1'b0, src1} + {1'b0, adder_b} + {32'b0, adder_cin};
    assign add_sub_res = adder_sum[31:0];

    // signed less than from the sign bits and the difference
    assign slt_res = {31'b0, (src1[31] & ~src2[31])
                           | (~(src1[31] ^ src2[31]) & add_sub_res[31])};

    assign sltu_res = {31'b0, ~adder_sum[32]}; // no carry out means a borrow

    assign shamt   = src2[4:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = word_t'($signed(src1) >>> shamt);

    always_comb begin
        result = ({32{alu_op[alu_add] | alu_op[alu_sub]}} & add_sub_res)
               | ({32{alu_op[alu_slt]}}  & slt_res)
               | ({32{alu_op[alu_sltu]}} & sltu_res)
               | ({32{alu_op[alu_and]}}  & (src1 & src2))
               | ({32{alu_op[alu_nor]}}  & ~(src1 | src2))
               | ({32{alu_op[alu_or]}}   & (src1 | src2))
               | ({32{alu_op[alu_xor]}}  & (src1 ^ src2))
               | ({32{alu_op[alu_sll]}}  & sll_res)
               | ({32{alu_op[alu_srl]}}  & srl_res)
               | ({32{alu_op[alu_sra]}}  & sra_res)
               | ({32{alu_op[alu_lui]}}  & src2); // immediate arrives already shifted
    end

endmodule

/* hw/la_regfile.sv */
`timescale 1ns/1ps

module la_regfile import la_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata; // r0 is never stored
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hw/la_cpu.sv */
`timescale 1ns/1ps

module la_cpu import la_pkg::*; #(
    parameter word_t reset_pc = 32'h1c00_0000
) (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_sram_we,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,

    output logic       data_sram_we,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_we,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    cpu_state_t state;
    cpu_state_t next_state;

    word_t pc;
    word_t inst_pc;
    word_t instr_q;
    word_t dec_instr;

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    alu_op_t  alu_op;
    word_t    imm;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     src_reg_is_rd;
    logic     is_load;
    logic     is_store;
    logic     is_branch_cond_eq;
    logic     is_branch_cond_ne;
    logic     is_jump_pc_rel;
    logic     is_jirl;
    logic     writes_reg;
    logic     dest_is_r1;

    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    logic     rf_we;
    reg_idx_t dest;

    word_t alu_src1;
    word_t alu_src2;
    word_t alu_result;
    word_t store_data;
    word_t result_q;

    logic  is_link;
    logic  branch_only;
    logic  rj_eq_rd;
    logic  br_taken;
    word_t br_target;
    word_t seq_pc;
    word_t next_pc;

    // the word is only on the SRAM bus during st_id, later states use the copy
    assign dec_instr = (state == st_id) ? inst_sram_rdata : instr_q;

    la_decoder u_decoder (
        .instr             (dec_instr),
        .rd                (rd),
        .rj                (rj),
        .rk                (rk),
        .alu_op            (alu_op),
        .imm               (imm),
        .src1_is_pc        (src1_is_pc),
        .src2_is_imm       (src2_is_imm),
        .src_reg_is_rd     (src_reg_is_rd),
        .is_load           (is_load),
        .is_store          (is_store),
        .is_branch_cond_eq (is_branch_cond_eq),
        .is_branch_cond_ne (is_branch_cond_ne),
        .is_jump_pc_rel    (is_jump_pc_rel),
        .is_jirl           (is_jirl),
        .writes_reg        (writes_reg),
        .dest_is_r1        (dest_is_r1)
    );

    assign rf_raddr2 = src_reg_is_rd ? rd : rk;
    assign rf_we     = (state == st_wb) && writes_reg;
    assign dest      = dest_is_r1 ? reg_idx_t'(1) : rd;

    la_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (result_q)
    );

    la_alu u_alu (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // branch resolution, all of it happens in st_id
    assign is_link     = is_jirl | dest_is_r1;
    assign branch_only = is_branch_cond_eq | is_branch_cond_ne | (is_jump_pc_rel & ~writes_reg);
    assign rj_eq_rd    = rf_rdata1 == rf_rdata2;
    assign br_taken    = (is_branch_cond_eq & rj_eq_rd) | (is_branch_cond_ne & ~rj_eq_rd)
                       | is_jump_pc_rel | is_jirl;
    assign br_target   = is_jirl ? (rf_rdata1 + imm) : (pc + imm);
    assign seq_pc      = pc + 32'd4;
    assign next_pc     = br_taken ? {br_target[31:2], 2'b00} : seq_pc; // fetch stays aligned

    always_comb begin
        next_state = state;
        unique case (state)
            st_if: begin
                next_state = st_id;
            end
            st_id: begin
                next_state = branch_only ? st_if : st_exe;
            end
            st_exe: begin
                if (is_load || is_store) begin
                    next_state = st_mem;
                end else if (writes_reg) begin
                    next_state = st_wb;
                end else begin
                    next_state = st_if; // unknown encoding retires silently
                end
            end
            st_mem: begin
                next_state = is_load ? st_wb : st_if;
            end
            st_wb: begin
                next_state = st_if;
            end
            default: begin
                next_state = st_if;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_if;
            pc    <= reset_pc;
        end else begin
            state <= next_state;
            if (state == st_id) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_id: begin
                instr_q    <= inst_sram_rdata;
                inst_pc    <= pc;
                alu_src1   <= src1_is_pc ? pc : rf_rdata1;
                if (is_link) begin
                    alu_src2 <= 32'd4;
                end else begin
                    alu_src2 <= src2_is_imm ? imm : rf_rdata2;
                end
                store_data <= rf_rdata2; // rd value for st.w
            end
            st_exe: begin
                result_q <= alu_result;
            end
            st_mem: begin
                if (is_load) begin
                    result_q <= data_sram_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    assign data_sram_we    = (state == st_exe) && is_store;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data;

    assign debug_wb_pc       = inst_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = result_q;

endmodule

/* test/la_cpu_checker.sv */
`timescale 1ns/1ps

module la_cpu_checker import la_pkg::*; (
    input logic       clk,
    input logic       reset,
    input cpu_state_t state,
    input logic       inst_sram_we,
    input word_t      inst_sram_addr,
    input logic       data_sram_we,
    input logic [3:0] debug_wb_rf_we
);

    int assert_fails = 0;

    a_store_single: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
    else begin
        assert_fails++;
        $error("data_sram_we stayed high for more than one cycle");
    end

    a_store_in_exe: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == st_exe)
    else begin
        assert_fails++;
        $error("data_sram_we is high outside the execute state");
    end

    a_trace_we_equal: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we == 4'b0000 || debug_wb_rf_we == 4'b1111)
    else begin
        assert_fails++;
        $error("the bits of debug_wb_rf_we differ");
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_addr[1:0] == 2'b00)
    else begin
        assert_fails++;
        $error("inst_sram_addr is not word aligned");
    end

    a_no_inst_write: assert property (@(posedge clk) !inst_sram_we)
    else begin
        assert_fails++;
        $error("inst_sram_we went high");
    end

endmodule

bind la_cpu la_cpu_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .inst_sram_we   (inst_sram_we),
    .inst_sram_addr (inst_sram_addr),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);

/* test/tb_la_cpu.sv */
`timescale 1ns/1ps

module tb_la_cpu import la_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       inst_sram_we;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t imem [1024];
    word_t dmem [1024];
    word_t ref_dmem [1024];
    word_t ref_rf [32];
    word_t prog [$];

    word_t    exp_pc [$];
    reg_idx_t exp_num [$];
    word_t    exp_val [$];
    word_t    exp_st_addr [$];
    word_t    exp_st_data [$];
    word_t    end_pc;

    logic checking = 1'b0;
    int   mismatches = 0;
    int   failures = 0;
    int   budget = 0; // instructions loaded so far, sizes the watchdog
    int   cycle_count = 0;

    la_cpu #(.reset_pc(32'h0)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // both SRAMs answer the address seen at an edge by the next edge
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= dmem[data_sram_addr[11:2]];
    end

    function automatic word_t enc_reg(logic [16:0] op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {op, rk, rj, rd}; // rk field holds ui5 for the shifts
    endfunction

    function automatic word_t enc_imm12(logic [9:0] op, reg_idx_t rd, reg_idx_t rj,
                                        logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic word_t enc_lu12i(reg_idx_t rd, logic [19:0] si20);
        return {op_lu12i_w, si20, rd};
    endfunction

    function automatic word_t enc_off16(logic [5:0] op, reg_idx_t rd, reg_idx_t rj,
                                        logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t enc_off26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    task automatic load_const(reg_idx_t r, word_t v);
        word_t hi;
        hi = v + 32'h800; // addi.w sign-extends the low part
        emit(enc_lu12i(r, hi[31:12]));
        emit(enc_imm12(op_addi_w, r, r, v[11:0]));
    endtask

    task automatic compare_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_reg(reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: write-back register got r%0d expected r%0d",
                     $time, got, exp);
        end
    endtask

    task automatic compare_store(word_t addr, word_t data);
        word_t ea;
        word_t ed;
        if (exp_st_addr.size() == 0) begin
            failures++;
            $display("A store to %h appeared that the program never makes", addr);
        end else begin
            ea = exp_st_addr.pop_front();
            ed = exp_st_data.pop_front();
            if (addr !== ea || data !== ed) begin
                mismatches++;
                $display("Mismatch at %0t: store got [%h] = %h expected [%h] = %h",
                         $time, addr, data, ea, ed);
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            compare_word(inst_sram_wdata, 32'h0, "instruction write data");
        end
        if (checking && debug_wb_rf_we != 4'b0000) begin
            if (exp_pc.size() == 0) begin
                failures++;
                $display("A register write-back at pc %h appeared that was not due", debug_wb_pc);
            end else begin
                compare_word(debug_wb_pc, exp_pc.pop_front(), "write-back pc");
                compare_reg(debug_wb_rf_wnum, exp_num.pop_front());
                compare_word(debug_wb_rf_wdata, exp_val.pop_front(), "write-back data");
            end
        end
        if (checking && data_sram_we) begin
            compare_store(data_sram_addr, data_sram_wdata);
        end
    end

    // instruction-set model, walks the program until the self-branch at its end
    task automatic run_model();
        word_t    pc;
        word_t    w;
        word_t    a;
        word_t    imm12;
        word_t    addr;
        word_t    off16;
        word_t    off26;
        word_t    res;
        word_t    nxt;
        reg_idx_t rd;
        logic     wr;
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = '0;
        end
        ref_dmem = dmem;
        pc = '0;
        for (int n = 0; n < 512; n++) begin
            w = imem[pc[11:2]];
            if (w == enc_off26(op_b, 26'd0)) begin
                end_pc = pc;
                return;
            end
            rd    = w[4:0];
            a     = ref_rf[w[9:5]];
            imm12 = {{20{w[21]}}, w[21:10]};
            addr  = a + imm12;
            off16 = {{14{w[25]}}, w[25:10], 2'b00};
            off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            nxt   = pc + 32'd4;
            res   = '0;
            wr    = 1'b1;
            case (1'b1)
                w[31:15] == op_add_w:   res = a + ref_rf[w[14:10]];
                w[31:15] == op_sub_w:   res = a - ref_rf[w[14:10]];
                w[31:15] == op_slt:     res = {31'b0, $signed(a) < $signed(ref_rf[w[14:10]])};
                w[31:15] == op_sltu:    res = {31'b0, a < ref_rf[w[14:10]]};
                w[31:15] == op_nor:     res = ~(a | ref_rf[w[14:10]]);
                w[31:15] == op_and:     res = a & ref_rf[w[14:10]];
                w[31:15] == op_or:      res = a | ref_rf[w[14:10]];
                w[31:15] == op_xor:     res = a ^ ref_rf[w[14:10]];
                w[31:15] == op_slli_w:  res = a << w[14:10];
                w[31:15] == op_srli_w:  res = a >> w[14:10];
                w[31:15] == op_srai_w:  res = word_t'($signed(a) >>> w[14:10]);
                w[31:22] == op_addi_w:  res = addr;
                w[31:25] == op_lu12i_w: res = {w[24:5], 12'b0};
                w[31:22] == op_ld_w:    res = ref_dmem[addr[11:2]];
                w[31:22] == op_st_w: begin
                    wr = 1'b0;
                    ref_dmem[addr[11:2]] = ref_rf[rd];
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(ref_rf[rd]);
                end
                w[31:26] == op_jirl: begin
                    res = pc + 32'd4;
                    nxt = a + off16; // rj is read before rd is written
                end
                w[31:26] == op_b: begin
                    wr  = 1'b0;
                    nxt = pc + off26;
                end
                w[31:26] == op_bl: begin
                    res = pc + 32'd4;
                    rd  = 5'd1;
                    nxt = pc + off26;
                end
                w[31:26] == op_beq: begin
                    wr = 1'b0;
                    if (a == ref_rf[rd]) nxt = pc + off16;
                end
                w[31:26] == op_bne: begin
                    wr = 1'b0;
                    if (a != ref_rf[rd]) nxt = pc + off16;
                end
                default: wr = 1'b0; // unknown encodings retire as no-ops
            endcase
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back(rd);
                exp_val.push_back(res);
                if (rd != 5'd0) ref_rf[rd] = res;
            end
            pc = nxt;
        end
        failures++;
        $display("The reference model never reached the end of the program");
    endtask

    task automatic begin_test();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = 32'hffc0_0000 | i; // unknown encodings
            dmem[i] = {i[15:0] ^ 16'h3c5a, ~i[15:0]};
        end
        prog.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
    endtask

    task automatic run_program(string name);
        emit(enc_off26(op_b, 26'd0));
        budget += prog.size();
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        run_model();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_word(inst_sram_addr, 32'h0, "first fetch address");
        checking = 1'b1;
        @(negedge clk);
        while (u_dut.state != st_if || inst_sram_addr != end_pc) begin
            @(negedge clk);
        end
        checking = 1'b0;
        while (exp_pc.size() > 0) begin
            failures++;
            $display("In %s the write-back of r%0d at pc %h never happened",
                     name, exp_num.pop_front(), exp_pc.pop_front());
            void'(exp_val.pop_front());
        end
        while (exp_st_addr.size() > 0) begin
            failures++;
            $display("In %s the store to %h never happened", name, exp_st_addr.pop_front());
            void'(exp_st_data.pop_front());
        end
    endtask

    task automatic test_reg_ops();
        begin_test();
        load_const(5'd1, $urandom());
        load_const(5'd2, $urandom());
        load_const(5'd3, $urandom());
        load_const(5'd4, $urandom());
        emit(enc_reg(op_add_w, 5'd5, 5'd1, 5'd2));
        emit(enc_reg(op_sub_w, 5'd6, 5'd1, 5'd2));
        emit(enc_reg(op_slt, 5'd7, 5'd1, 5'd2));
        emit(enc_reg(op_sltu, 5'd8, 5'd1, 5'd2));
        emit(enc_reg(op_nor, 5'd9, 5'd3, 5'd4));
        emit(enc_reg(op_and, 5'd10, 5'd3, 5'd4));
        emit(enc_reg(op_or, 5'd11, 5'd1, 5'd3));
        emit(enc_reg(op_xor, 5'd12, 5'd2, 5'd4));
        emit(enc_reg(op_slt, 5'd13, 5'd4, 5'd3));
        emit(enc_reg(op_sltu, 5'd14, 5'd4, 5'd3));
        emit(enc_reg(op_slt, 5'd15, 5'd1, 5'd1));
        run_program("register ops");
    endtask

    task automatic test_immediates();
        word_t r;
        begin_test();
        r = $urandom();
        load_const(5'd1, $urandom());
        emit(enc_imm12(op_addi_w, 5'd2, 5'd1, {1'b1, r[10:0]}));
        emit(enc_reg(op_slli_w, 5'd3, 5'd1, r[4:0]));
        emit(enc_reg(op_srli_w, 5'd4, 5'd1, r[9:5]));
        emit(enc_reg(op_srai_w, 5'd5, 5'd1, r[14:10]));
        emit(enc_lu12i(5'd6, r[31:12]));
        emit(enc_imm12(op_addi_w, 5'd7, 5'd0, 12'h800));
        emit(enc_reg(op_srai_w, 5'd8, 5'd7, r[19:15]));
        emit(enc_reg(op_srli_w, 5'd9, 5'd7, r[24:20]));
        run_program("immediates");
    endtask

    task automatic test_memory();
        word_t r;
        word_t base;
        begin_test();
        r = $urandom();
        base = 32'h100 + {24'b0, r[7:2], 2'b00};
        dmem[10'hc0] = $urandom(); // preloaded word at 0x300
        load_const(5'd1, $urandom());
        emit(enc_imm12(op_addi_w, 5'd2, 5'd0, base[11:0]));
        emit(enc_imm12(op_st_w, 5'd1, 5'd2, 12'd8));
        emit(enc_imm12(op_ld_w, 5'd3, 5'd2, 12'd8));
        emit(enc_imm12(op_ld_w, 5'd4, 5'd0, 12'h300));
        emit(enc_imm12(op_st_w, 5'd4, 5'd2, 12'hffc));
        emit(enc_imm12(op_ld_w, 5'd5, 5'd2, 12'hffc));
        run_program("memory");
    endtask

    task automatic test_control();
        begin_test();
        emit(enc_imm12(op_addi_w, 5'd1, 5'd0, 12'd5));
        emit(enc_imm12(op_addi_w, 5'd2, 5'd0, 12'd5));
        emit(enc_off16(op_beq, 5'd2, 5'd1, 16'd2));    // 0x08 taken to 0x10
        emit(enc_imm12(op_addi_w, 5'd3, 5'd0, 12'd1));
        emit(enc_off16(op_bne, 5'd2, 5'd1, 16'd2));    // 0x10 falls through
        emit(enc_imm12(op_addi_w, 5'd4, 5'd0, 12'd2));
        emit(enc_imm12(op_addi_w, 5'd2, 5'd0, 12'd7));
        emit(enc_off16(op_bne, 5'd2, 5'd1, 16'd2));    // 0x1c taken to 0x24
        emit(enc_imm12(op_addi_w, 5'd5, 5'd0, 12'd3));
        emit(enc_off16(op_beq, 5'd2, 5'd1, 16'd2));    // 0x24 falls through
        emit(enc_imm12(op_addi_w, 5'd6, 5'd0, 12'd4));
        emit(enc_off26(op_b, 26'd2));                  // 0x2c to 0x34
        emit(enc_imm12(op_addi_w, 5'd7, 5'd0, 12'd5));
        emit(enc_off26(op_bl, 26'd3));                 // 0x34 calls 0x40
        emit(enc_imm12(op_addi_w, 5'd8, 5'd0, 12'd6)); // the return lands here
        emit(enc_off26(op_b, 26'd3));                  // 0x3c jumps over the call target
        emit(enc_imm12(op_addi_w, 5'd9, 5'd0, 12'd9));
        emit(enc_off16(op_jirl, 5'd0, 5'd1, 16'd0));   // return through r1
        run_program("control flow");
    endtask

    task automatic test_r0_and_reset();
        word_t r;
        begin_test();
        r = $urandom();
        emit(enc_imm12(op_addi_w, 5'd0, 5'd0, r[11:0]));
        emit(enc_reg(op_add_w, 5'd1, 5'd0, 5'd0));
        emit(enc_lu12i(5'd0, r[31:12]));
        emit(enc_reg(op_or, 5'd2, 5'd0, 5'd0));
        emit(enc_imm12(op_addi_w, 5'd3, 5'd0, 12'h7ff));
        emit(enc_reg(op_sltu, 5'd4, 5'd0, 5'd3));
        run_program("register zero");
    endtask

    initial begin
        while (cycle_count <= budget * 20 + 2000) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a program never reached its final branch",
                 cycle_count);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        void'($urandom(32'he53d9040));
        test_reg_ops();
        test_immediates();
        test_memory();
        test_control();
        test_r0_and_reset();
        failures += u_dut.u_checker.assert_fails;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/la_pkg.sv
hw/la_decoder.sv
hw/la_alu.sv
hw/la_regfile.sv
hw/la_cpu.sv
test/la_cpu_checker.sv
test/tb_la_cpu.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_la_cpu \
		-Mdir $(OBJ_DIR) -o sim_la_cpu -f list.f
	./$(OBJ_DIR)/sim_la_cpu +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
